// ==== compile.f ====
rtl/sd_spi_pkg.sv
rtl/sd_block_pkg.sv
rtl/word_stream_if.sv
rtl/sector_if.sv
rtl/sd_pattern_writer.sv
rtl/sd_sector_buffer.sv
rtl/sd_spi_byte_engine.sv
rtl/sd_block_writer.sv
rtl/sd_write_top.sv
tests/sd_card_model.sv
tests/tb_sd_write_top.sv

// ==== rtl/sd_block_pkg.sv ====
`default_nettype none

package sd_block_pkg;

  // Pattern word that goes out MSB first
  typedef logic [31:0] word_t;

  // Word position inside a 512-byte sector
  typedef logic [6:0] word_index_t;

  // Sectors per job
  typedef logic [7:0] sector_count_t;

  localparam int WORDS_PER_SECTOR = 128;

endpackage

`default_nettype wire

// ==== rtl/sd_block_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_block_writer import sd_spi_pkg::*, sd_block_pkg::*; #(
  parameter int CLK_DIV = 2
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  sd_block_addr_t first_block,
  input  logic           sd_miso,
  sector_if.writer       sector,
  output logic           abort,
  output logic           job_end,
  output logic           sd_cs,
  output logic           sd_sclk,
  output logic           sd_mosi
);

  localparam int CNT_W      = $clog2(BUSY_POLL_LIMIT);
  localparam int DATA_BYTES = WORDS_PER_SECTOR * 4;

  localparam logic [CNT_W-1:0] CMD_LAST  = CNT_W'(6);  // Filler, command, address, CRC
  localparam logic [CNT_W-1:0] R1_LAST   = CNT_W'(R1_POLL_LIMIT - 1);
  localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(DATA_BYTES - 1);
  localparam logic [CNT_W-1:0] BUSY_LAST = CNT_W'(BUSY_POLL_LIMIT - 1);

  typedef enum logic [3:0] {
    IDLE,
    CMD,
    R1_WAIT,
    TOKEN,
    DATA,
    CRC,
    RESP,
    BUSY,
    RELEASE
  } state_t;

  state_t           state;
  sd_block_addr_t   block_addr;
  logic [CNT_W-1:0] byte_cnt;   // Byte within the current state
  word_index_t      word_idx;   // Next word to fetch
  word_t            word_sr;    // Word being sent
  logic             failed;
  logic             pending;    // Byte in flight
  logic             byte_go;
  logic             byte_done;
  logic             bad_byte;
  sd_byte_t         tx_byte;
  sd_byte_t         rx_byte;

  sd_spi_byte_engine #(
    .CLK_DIV (CLK_DIV)
  ) engine (
    .clk       (clk),
    .rst       (rst),
    .go        (byte_go),
    .tx_byte   (tx_byte),
    .sd_miso   (sd_miso),
    .rx_byte   (rx_byte),
    .byte_done (byte_done),
    .sd_sclk   (sd_sclk),
    .sd_mosi   (sd_mosi)
  );

  assign sector.rd_index = word_idx;

  always_comb begin
    case (state)
      CMD: begin
        case (byte_cnt[2:0])
          3'd1:    tx_byte = CMD24_BYTE;
          3'd2:    tx_byte = block_addr[31:24];
          3'd3:    tx_byte = block_addr[23:16];
          3'd4:    tx_byte = block_addr[15:8];
          3'd5:    tx_byte = block_addr[7:0];
          default: tx_byte = IDLE_BYTE;  // Leading filler and dummy CRC
        endcase
      end
      TOKEN:   tx_byte = byte_cnt[0] ? START_TOKEN : IDLE_BYTE;
      DATA:    tx_byte = word_sr[31:24];
      default: tx_byte = IDLE_BYTE;
    endcase
  end

  // Judges the byte the card just returned
  always_comb begin
    case (state)
      R1_WAIT: bad_byte = rx_byte[7] ? (byte_cnt == R1_LAST) : (rx_byte != 8'h00);
      RESP:    bad_byte = (rx_byte[4:0] != DATA_ACCEPTED);
      BUSY:    bad_byte = (rx_byte == 8'h00) && (byte_cnt == BUSY_LAST);
      default: bad_byte = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      sd_cs        <= 1'b1;
      byte_go      <= 1'b0;
      pending      <= 1'b0;
      byte_cnt     <= '0;
      word_idx     <= '0;
      failed       <= 1'b0;
      abort        <= 1'b0;
      job_end      <= 1'b0;
      sector.taken <= 1'b0;
    end else begin
      byte_go      <= 1'b0;
      abort        <= 1'b0;
      job_end      <= 1'b0;
      sector.taken <= 1'b0;
      if (state == IDLE) begin
        if (start) block_addr <= first_block;
        // Buffer still shows the old bank during a taken or abort pulse
        if (sector.sector_ready && !sector.taken && !abort) begin
          state    <= CMD;
          sd_cs    <= 1'b0;
          byte_cnt <= '0;
          word_idx <= '0;
          failed   <= 1'b0;
        end
      end else if (!pending) begin
        byte_go <= 1'b1;
        pending <= 1'b1;
      end else if (byte_done) begin
        pending  <= 1'b0;
        byte_cnt <= byte_cnt + CNT_W'(1);
        if (bad_byte) begin
          failed   <= 1'b1;
          sd_cs    <= 1'b1;
          state    <= RELEASE;
          byte_cnt <= '0;
        end else begin
          case (state)
            CMD: begin
              if (byte_cnt == CMD_LAST) begin
                state    <= R1_WAIT;
                byte_cnt <= '0;
              end
            end
            R1_WAIT: begin
              if (!rx_byte[7]) begin  // R1 arrived and was zero
                state    <= TOKEN;
                byte_cnt <= '0;
              end
            end
            TOKEN: begin
              if (byte_cnt[0]) begin
                state    <= DATA;
                byte_cnt <= '0;
                word_sr  <= sector.rd_data;
                word_idx <= word_idx + 7'd1;
              end
            end
            DATA: begin
              if (byte_cnt[1:0] == 2'd3) begin
                word_sr  <= sector.rd_data;  // Prefetched four bytes ago
                word_idx <= word_idx + 7'd1;
              end else begin
                word_sr <= word_sr << 8;
              end
              if (byte_cnt == DATA_LAST) begin
                state    <= CRC;
                byte_cnt <= '0;
              end
            end
            CRC: begin
              if (byte_cnt[0]) begin
                state    <= RESP;
                byte_cnt <= '0;
              end
            end
            RESP: begin
              state    <= BUSY;
              byte_cnt <= '0;
            end
            BUSY: begin
              if (rx_byte != 8'h00) begin  // Card done programming
                state    <= RELEASE;
                sd_cs    <= 1'b1;
                byte_cnt <= '0;
              end
            end
            RELEASE: begin
              state <= IDLE;
              if (failed) begin
                abort   <= 1'b1;
                job_end <= 1'b1;
              end else begin
                sector.taken <= 1'b1;
                block_addr   <= block_addr + 32'd1;
                job_end      <= sector.is_last;
              end
            end
            default: state <= IDLE;
          endcase
        end
      end
    end
  end

  // Card stays selected from the command through the busy period
  assert property (@(posedge clk) disable iff (rst)
    state inside {CMD, R1_WAIT, TOKEN, DATA, CRC, RESP, BUSY} |-> !sd_cs);

  // Job only ends with the card released and SCLK parked
  assert property (@(posedge clk) disable iff (rst)
    job_end |-> sd_cs && !sd_sclk);

endmodule

`default_nettype wire

// ==== rtl/sd_pattern_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_pattern_writer import sd_block_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  sector_count_t sector_count,
  input  word_t         pattern_base,
  input  logic          abort,
  input  logic          job_end,
  output logic          busy,
  output logic          done,
  output logic          write_error,
  word_stream_if.source stream
);

  localparam word_index_t LAST_INDEX = word_index_t'(WORDS_PER_SECTOR - 1);
  // From word 127 of sector j to word 0 of sector j+1
  localparam word_t SECTOR_JUMP = word_t'(256 - (WORDS_PER_SECTOR - 1));

  typedef enum logic [1:0] {
    IDLE,
    STREAM,
    WAIT_END
  } state_t;

  state_t        state;
  sector_count_t count_q;
  sector_count_t sector_idx;
  word_index_t   word_idx;
  word_t         word_q;    // Current pattern value
  logic          last_sector;

  // A count of zero wraps and runs 256 sectors
  assign last_sector = (sector_idx == sector_count_t'(count_q - 8'd1));

  assign stream.valid = (state == STREAM);
  assign stream.data  = word_q;
  assign stream.last  = last_sector && (word_idx == LAST_INDEX);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      busy        <= 1'b0;
      done        <= 1'b0;
      write_error <= 1'b0;
      sector_idx  <= '0;
      word_idx    <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            state       <= STREAM;
            busy        <= 1'b1;
            write_error <= 1'b0;
            count_q     <= sector_count;
            word_q      <= pattern_base;
            sector_idx  <= '0;
            word_idx    <= '0;
          end
        end
        STREAM: begin
          if (stream.valid && stream.ready) begin
            word_idx <= word_idx + 7'd1;
            if (word_idx == LAST_INDEX) begin
              sector_idx <= sector_idx + 8'd1;
              word_q     <= word_q + SECTOR_JUMP;
            end else begin
              word_q <= word_q + 32'd1;
            end
            if (stream.last) state <= WAIT_END;  // Rest is up to the writer
          end
        end
        WAIT_END: ;
        default: state <= IDLE;
      endcase

      // Writer closes the job, either after the last sector or on an error
      if (job_end && state != IDLE) begin
        state       <= IDLE;
        busy        <= 1'b0;
        done        <= 1'b1;
        write_error <= abort;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sd_sector_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_sector_buffer import sd_block_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        abort,
  word_stream_if.sink stream,
  sector_if.buffer    sector
);

  localparam int          DEPTH      = 2 * WORDS_PER_SECTOR;
  localparam word_index_t LAST_INDEX = word_index_t'(WORDS_PER_SECTOR - 1);

  word_t       mem [DEPTH];  // Bank is the top address bit
  logic        wr_bank;
  logic        rd_bank;
  logic [1:0]  full;
  logic [1:0]  last_flag;
  word_index_t wr_idx;
  logic        wr_en;

  assign stream.ready = !full[wr_bank];  // Holds the producer when both banks wait
  assign wr_en        = stream.valid && stream.ready && !abort;

  assign sector.sector_ready = full[rd_bank];
  assign sector.is_last      = last_flag[rd_bank];

  always_ff @(posedge clk) begin
    if (wr_en) mem[{wr_bank, wr_idx}] <= stream.data;
    sector.rd_data <= mem[{rd_bank, sector.rd_index}];
  end

  always_ff @(posedge clk) begin
    if (rst || abort) begin
      wr_bank   <= 1'b0;
      rd_bank   <= 1'b0;
      full      <= 2'b00;
      last_flag <= 2'b00;
      wr_idx    <= '0;
    end else begin
      if (wr_en) begin
        wr_idx <= wr_idx + 7'd1;
        if (wr_idx == LAST_INDEX) begin  // Bank complete
          full[wr_bank]      <= 1'b1;
          last_flag[wr_bank] <= stream.last;
          wr_bank            <= ~wr_bank;
        end
      end
      // Write and take always hit different banks
      if (sector.taken) begin
        full[rd_bank] <= 1'b0;
        rd_bank       <= ~rd_bank;
      end
    end
  end

  // Producer keeps its word steady while both banks are full
  assert property (@(posedge clk) disable iff (rst || abort)
    stream.valid && !stream.ready |=> stream.valid && $stable(stream.data));

  // Writer only releases a bank that holds a sector
  assert property (@(posedge clk) disable iff (rst)
    sector.taken |-> sector.sector_ready);

endmodule

`default_nettype wire

// ==== rtl/sd_spi_byte_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_spi_byte_engine import sd_spi_pkg::*; #(
  parameter int CLK_DIV = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     go,
  input  sd_byte_t tx_byte,
  input  logic     sd_miso,
  output sd_byte_t rx_byte,
  output logic     byte_done,
  output logic     sd_sclk,
  output logic     sd_mosi
);

  localparam int               DIV_W    = $clog2(CLK_DIV + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

  logic             active;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       edge_cnt;   // 16 SCLK edges per byte
  sd_byte_t         tx_shift;
  sd_byte_t         rx_shift;
  logic             half_end;

  assign half_end = active && (div_cnt == DIV_LAST);

  always_ff @(posedge clk) begin
    if (rst) begin
      active    <= 1'b0;
      div_cnt   <= '0;
      edge_cnt  <= '0;
      byte_done <= 1'b0;
      sd_sclk   <= 1'b0;
      sd_mosi   <= 1'b1;
    end else begin
      byte_done <= 1'b0;
      if (active) begin
        div_cnt <= half_end ? '0 : div_cnt + 1'b1;
        if (half_end) begin
          sd_sclk  <= ~sd_sclk;
          edge_cnt <= edge_cnt + 4'd1;
          if (!sd_sclk) begin
            rx_shift <= {rx_shift[6:0], sd_miso};  // Rising edge samples
          end else begin
            sd_mosi  <= tx_shift[7];               // Falling edge shifts
            tx_shift <= {tx_shift[6:0], 1'b1};
          end
          if (edge_cnt == 4'd15) begin
            active    <= 1'b0;
            byte_done <= 1'b1;
            rx_byte   <= rx_shift;
          end
        end
      end else if (go) begin
        // First bit goes out ahead of the first rising edge
        active   <= 1'b1;
        div_cnt  <= '0;
        edge_cnt <= '0;
        sd_mosi  <= tx_byte[7];
        tx_shift <= {tx_byte[6:0], 1'b1};  // Ones refill so MOSI idles high
      end
    end
  end

  // Writer never starts a byte over a running one
  assert property (@(posedge clk) disable iff (rst) go |-> !active);

  // A byte is sixteen half periods of SCLK
  assert property (@(posedge clk) disable iff (rst)
    go |=> ##(16 * CLK_DIV) byte_done);

endmodule

`default_nettype wire

// ==== rtl/sd_spi_pkg.sv ====
`default_nettype none

package sd_spi_pkg;

  // One byte on the SPI wires
  typedef logic [7:0] sd_byte_t;

  // Counts 512-byte sectors since the card uses block addressing
  typedef logic [31:0] sd_block_addr_t;

  // Start bit 0 and host bit 1 ahead of the 6-bit index 24
  localparam sd_byte_t CMD24_BYTE = 8'h58;

  // Single-block write data token
  localparam sd_byte_t START_TOKEN = 8'hFE;

  // MOSI held high. Also serves as the dummy CRC byte
  localparam sd_byte_t IDLE_BYTE = 8'hFF;

  // Low 5 bits of the data response token
  localparam logic [4:0] DATA_ACCEPTED = 5'b00101;

  // Bytes to wait for R1 after the command frame (NCR)
  localparam int R1_POLL_LIMIT = 8;

  // Bytes of 0x00 allowed while the card programs the block
  localparam int BUSY_POLL_LIMIT = 4096;

endpackage

`default_nettype wire

// ==== rtl/sd_write_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sd_write_top import sd_spi_pkg::*, sd_block_pkg::*; #(
  parameter int CLK_DIV = 2
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  sd_block_addr_t first_block,
  input  sector_count_t  sector_count,
  input  word_t          pattern_base,
  input  logic           sd_miso,
  output logic           busy,
  output logic           done,
  output logic           write_error,
  output logic           sd_sclk,
  output logic           sd_cs,
  output logic           sd_mosi
);

  logic job_start;
  logic abort;
  logic job_end;

  // A start during a job is dropped
  assign job_start = start && !busy;

  word_stream_if stream_bus ();
  sector_if      sector_bus ();

  sd_pattern_writer producer (
    .clk          (clk),
    .rst          (rst),
    .start        (job_start),
    .sector_count (sector_count),
    .pattern_base (pattern_base),
    .abort        (abort),
    .job_end      (job_end),
    .busy         (busy),
    .done         (done),
    .write_error  (write_error),
    .stream       (stream_bus.source)
  );

  sd_sector_buffer buffer (
    .clk    (clk),
    .rst    (rst),
    .abort  (abort),
    .stream (stream_bus.sink),
    .sector (sector_bus.buffer)
  );

  sd_block_writer #(
    .CLK_DIV (CLK_DIV)
  ) writer (
    .clk         (clk),
    .rst         (rst),
    .start       (job_start),
    .first_block (first_block),
    .sd_miso     (sd_miso),
    .sector      (sector_bus.writer),
    .abort       (abort),
    .job_end     (job_end),
    .sd_cs       (sd_cs),
    .sd_sclk     (sd_sclk),
    .sd_mosi     (sd_mosi)
  );

endmodule

`default_nettype wire

// ==== rtl/sector_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Finished sector handed from buffer to block writer
interface sector_if import sd_block_pkg::*; ();

  logic        sector_ready;  // A full bank is waiting
  logic        is_last;       // That bank closes the job
  word_index_t rd_index;
  word_t       rd_data;       // One clock behind rd_index
  logic        taken;         // Frees the bank

  modport buffer (
    output sector_ready,
    output is_last,
    output rd_data,
    input  rd_index,
    input  taken
  );

  modport writer (
    input  sector_ready,
    input  is_last,
    input  rd_data,
    output rd_index,
    output taken
  );

endinterface

`default_nettype wire

// ==== rtl/word_stream_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Pattern words from producer to sector buffer
interface word_stream_if import sd_block_pkg::*; ();

  logic  valid;
  logic  ready;
  word_t data;
  logic  last;  // Word 127 of the final sector

  modport source (output valid, output data, output last, input ready);
  modport sink   (input valid, input data, input last, output ready);

endinterface

`default_nettype wire

// ==== tests/sd_card_model.sv ====
`timescale 1ns/1ns
`default_nettype none

// SPI-mode SD card that accepts CMD24 writes and keeps the received blocks
module sd_card_model import sd_spi_pkg::*; #(
  parameter int MAX_BLOCKS = 32
) (
  input  logic     sd_sclk,
  input  logic     sd_cs,
  input  logic     sd_mosi,
  input  sd_byte_t r1_value,   // R1 returned to every command
  input  sd_byte_t resp_byte,  // Data response token after each block
  output logic     sd_miso
);

  localparam int DATA_BYTES = 512;

  typedef enum {
    M_CMD,
    M_ARG,
    M_TOKEN,
    M_DATA
  } mode_t;

  // Captured traffic that the testbench reads
  sd_byte_t       data_mem [MAX_BLOCKS][DATA_BYTES];
  sd_block_addr_t cmd_addr [MAX_BLOCKS];
  int             cmd_count = 0;
  int             token_count = 0;

  mode_t          mode = M_CMD;
  sd_byte_t       rx_sr = IDLE_BYTE;
  sd_byte_t       out_sr = IDLE_BYTE;
  logic [2:0]     bit_cnt = 3'd0;
  int             arg_cnt = 0;
  int             data_cnt = 0;
  sd_block_addr_t arg_addr = '0;
  sd_byte_t       reply_q [$];   // Bytes waiting to go out on MISO
  int             rand_seed = 47;
  logic           seeded = 1'b0;

  assign sd_miso = (sd_cs === 1'b0) ? out_sr[7] : 1'b1;

  task automatic take_byte(input sd_byte_t b);
    int busy_len;
    case (mode)
      M_CMD: begin
        if (b == CMD24_BYTE) begin
          mode    = M_ARG;
          arg_cnt = 0;
        end
      end
      M_ARG: begin
        if (arg_cnt < 4) arg_addr = {arg_addr[23:0], b};  // Address MSB first
        arg_cnt = arg_cnt + 1;
        if (arg_cnt == 5) begin  // CRC byte closes the frame
          cmd_addr[cmd_count] = arg_addr;
          cmd_count = cmd_count + 1;
          reply_q.push_back(IDLE_BYTE);  // One filler before R1
          reply_q.push_back(r1_value);
          mode = M_TOKEN;  // A token after a rejected command still counts
        end
      end
      M_TOKEN: begin
        if (b == START_TOKEN) begin
          token_count = token_count + 1;
          data_cnt    = 0;
          mode        = M_DATA;
        end
      end
      M_DATA: begin
        if (data_cnt < DATA_BYTES) data_mem[token_count-1][data_cnt] = b;
        data_cnt = data_cnt + 1;
        if (data_cnt == DATA_BYTES + 2) begin  // Both CRC bytes seen
          reply_q.push_back(resp_byte);
          busy_len = int'($urandom % 20) + 1;
          repeat (busy_len) reply_q.push_back(8'h00);
          mode = M_CMD;
        end
      end
      default: mode = M_CMD;
    endcase
  endtask

  always @(sd_sclk) begin
    if (!seeded) begin
      void'($urandom(rand_seed));
      seeded = 1'b1;
    end
    if (sd_cs !== 1'b0) begin
      // Deselect starts the next frame clean
      mode    = M_CMD;
      bit_cnt = 3'd0;
      out_sr  = IDLE_BYTE;
      reply_q.delete();
    end else if (sd_sclk) begin
      rx_sr   = {rx_sr[6:0], sd_mosi};  // Sample on rising edge
      bit_cnt = bit_cnt + 3'd1;
      if (bit_cnt == 3'd0) take_byte(rx_sr);
    end else if (bit_cnt == 3'd0) begin
      out_sr = (reply_q.size() > 0) ? reply_q.pop_front() : IDLE_BYTE;
    end else begin
      out_sr = {out_sr[6:0], 1'b1};
    end
  end

endmodule

`default_nettype wire

// ==== tests/sd_write_tests.txt ====
// Columns, all hex: first_block sector_count pattern_base r1 data_response expect_error
// One job per line, run in order
00000100 01 12345678 00 E5 0
00002000 04 A0000000 00 E5 0
00000300 02 00000000 04 E5 1
00000400 03 55AA0000 00 0B 1
00000401 01 11110000 00 E5 0
7FFFFFFE 02 FFFFFF00 00 E5 0

// ==== tests/tb_sd_write_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sd_write_top import sd_spi_pkg::*, sd_block_pkg::*; ();

  localparam int MAX_JOBS          = 16;
  localparam int COLS              = 6;
  localparam int CYCLES_PER_SECTOR = 20000;

  logic           clk = 1'b0;
  logic           rst;
  logic           start;
  sd_block_addr_t first_block;
  sector_count_t  sector_count;
  word_t          pattern_base;
  logic           sd_miso;
  logic           busy;
  logic           done;
  logic           write_error;
  logic           sd_sclk;
  logic           sd_cs;
  logic           sd_mosi;
  sd_byte_t       r1_value;
  sd_byte_t       resp_byte;

  logic [31:0] job_table [COLS*MAX_JOBS];  // Six columns per job
  int          job_count;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  sd_write_top #(
    .CLK_DIV (2)
  ) DUT (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .first_block  (first_block),
    .sector_count (sector_count),
    .pattern_base (pattern_base),
    .sd_miso      (sd_miso),
    .busy         (busy),
    .done         (done),
    .write_error  (write_error),
    .sd_sclk      (sd_sclk),
    .sd_cs        (sd_cs),
    .sd_mosi      (sd_mosi)
  );

  sd_card_model card (
    .sd_sclk   (sd_sclk),
    .sd_cs     (sd_cs),
    .sd_mosi   (sd_mosi),
    .r1_value  (r1_value),
    .resp_byte (resp_byte),
    .sd_miso   (sd_miso)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Run did not finish within %0d clock cycles", cycle_limit);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) fail_run($sformatf("error %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_block(input string name, input sd_block_addr_t got,
                             input sd_block_addr_t exp);
    if (got !== exp) fail_run($sformatf("error %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) fail_run($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // Runs one job from the table and the idle checks after it
  task automatic run_job(input int idx);
    sd_block_addr_t blk;
    sector_count_t  cnt;
    word_t          base;
    word_t          got;
    logic           exp_err;
    int             cmd_base;
    int             tok_base;
    int             n_cmd;
    int             n_tok;
    int             waited;
    int             t;
    blk       = job_table[idx*COLS];
    cnt       = sector_count_t'(job_table[idx*COLS+1]);
    base      = job_table[idx*COLS+2];
    r1_value  = sd_byte_t'(job_table[idx*COLS+3]);
    resp_byte = sd_byte_t'(job_table[idx*COLS+4]);
    exp_err   = job_table[idx*COLS+5][0];
    cmd_base  = card.cmd_count;
    tok_base  = card.token_count;

    first_block  = blk;
    sector_count = cnt;
    pattern_base = base;
    start        = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    waited = 0;
    while (done !== 1'b1) begin
      check_flag("busy", busy, 1'b1);
      if (waited == 8) begin  // Second start mid-job
        first_block  = ~blk;
        pattern_base = ~base;
        start        = 1'b1;
      end else begin
        start = 1'b0;
      end
      @(negedge clk);
      waited++;
    end
    check_flag("busy", busy, 1'b0);
    check_flag("write_error", write_error, exp_err);

    // An error stops the job at its first sector
    n_cmd = exp_err ? 1 : int'(cnt);
    n_tok = (r1_value != 8'h00) ? 0 : n_cmd;
    check_count("card.cmd_count", card.cmd_count - cmd_base, n_cmd);
    check_count("card.token_count", card.token_count - tok_base, n_tok);
    for (int s = 0; s < n_cmd; s++) begin
      check_block("card.cmd_addr", card.cmd_addr[cmd_base+s], blk + sd_block_addr_t'(s));
    end
    for (int s = 0; s < n_tok; s++) begin
      t = tok_base + s;
      for (int k = 0; k < WORDS_PER_SECTOR; k++) begin
        got = {card.data_mem[t][4*k], card.data_mem[t][4*k+1],
               card.data_mem[t][4*k+2], card.data_mem[t][4*k+3]};
        check_word("card.data_mem", got, base + word_t'(s * 256 + k));
      end
    end

    repeat (4) begin
      @(negedge clk);
      check_flag("done", done, 1'b0);
      check_flag("write_error", write_error, exp_err);
      check_flag("sd_cs", sd_cs, 1'b1);
      check_flag("sd_sclk", sd_sclk, 1'b0);
    end
  endtask

  initial begin
    int total_sectors;
    rst          = 1'b1;
    start        = 1'b0;
    first_block  = '0;
    sector_count = '0;
    pattern_base = '0;
    r1_value     = 8'h00;
    resp_byte    = 8'hE5;

    // Unused rows keep an error column above 1
    for (int i = 0; i < COLS * MAX_JOBS; i++) job_table[i] = '1;
    $readmemh("tests/sd_write_tests.txt", job_table);
    job_count     = 0;
    total_sectors = 0;
    while (job_count < MAX_JOBS && job_table[job_count*COLS+5] <= 32'd1) begin
      total_sectors += int'(job_table[job_count*COLS+1]);
      job_count++;
    end
    if (job_count == 0) fail_run("No jobs found in tests/sd_write_tests.txt");
    cycle_limit = total_sectors * CYCLES_PER_SECTOR;

    repeat (3) @(negedge clk);
    rst = 1'b0;
    check_flag("sd_cs", sd_cs, 1'b1);
    check_flag("sd_sclk", sd_sclk, 1'b0);
    check_flag("sd_mosi", sd_mosi, 1'b1);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("write_error", write_error, 1'b0);

    for (int i = 0; i < job_count; i++) run_job(i);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
